/* dcache_pkg.sv */
// Geometry of the L1 data cache and the types that carry its widths
package dcache_pkg;

	// Four ways of thirty-two sets, each line sixty-four bytes wide
	localparam int way_numb   = 4;
	localparam int set_numb   = 32;
	localparam int line_bytes = 64;

	// The address is split into tag, set index and byte offset
	localparam int addr_w   = 32;
	localparam int offset_w = $clog2(line_bytes);
	localparam int index_w  = $clog2(set_numb);
	localparam int tag_w    = addr_w - index_w - offset_w;

	typedef logic [$clog2(way_numb)-1:0] way_idx_t;
	typedef logic [index_w-1:0]          set_idx_t;
	typedef logic [tag_w-1:0]            tag_t;
	typedef logic [offset_w-1:0]         offset_t;

	// A full cache line and its byte enables
	typedef logic [line_bytes*8-1:0] line_t;
	typedef logic [line_bytes-1:0]   byte_mask_t;

	// One bit per way, used for the tag match vector
	typedef logic [way_numb-1:0] way_mask_t;

	// The data bank is addressed by the set with the way below it
	typedef logic [index_w+$bits(way_idx_t)-1:0] bank_addr_t;

	// Tag sits in the upper bits, offset in the lower ones
	typedef struct packed {
		tag_t     tag;
		set_idx_t index;
		offset_t  offset;
	} dcache_address_t;

endpackage

/* lsu_pkg.sv */
// Requests, way state, controller commands and results of the load/store pipe
package lsu_pkg;

	localparam int thread_numb = 8;

	typedef logic [$clog2(thread_numb)-1:0] thread_id_t;

	// Request handed over by the tag stage
	typedef struct packed {
		logic                        valid;
		thread_id_t                  thread_id;
		logic                        is_load;
		dcache_pkg::dcache_address_t address;
		dcache_pkg::line_t           store_value;
		dcache_pkg::byte_mask_t      store_mask;
	} ldst2_req_t;

	// Tag and privileges of one way in the addressed set
	typedef struct packed {
		dcache_pkg::tag_t tag;
		logic             can_read;
		logic             can_write;
	} way_state_t;

	typedef way_state_t [dcache_pkg::way_numb-1:0] way_state_array_t;

	// Controller command whose line and set travel on the request's fields
	typedef struct packed {
		logic                 data_valid;
		logic                 evict;
		dcache_pkg::way_idx_t way;
	} cc_update_t;

	// Controller read of any line through the second bank port
	typedef struct packed {
		logic                 valid;
		dcache_pkg::set_idx_t set;
		dcache_pkg::way_idx_t way;
	} snoop_req_t;

	// What the stage does with the current cycle
	typedef enum logic [2:0] {
		idle,
		load_hit,
		load_miss,
		store_hit,
		store_miss,
		data_update,
		replacement
	} access_kind_t;

	// Registered outcome towards writeback and the cache controller
	typedef struct packed {
		logic                        valid;
		logic                        miss;
		logic                        evict;
		thread_id_t                  thread_id;
		dcache_pkg::dcache_address_t address;
		dcache_pkg::byte_mask_t      store_mask;
	} ldst3_result_t;

endpackage

/* hit_miss_unit.sv */
`timescale 1ns/1ns

module hit_miss_unit (
	input  lsu_pkg::ldst2_req_t       ldst2,
	input  lsu_pkg::way_state_array_t way_state,
	input  lsu_pkg::cc_update_t       cc_update,
	output lsu_pkg::access_kind_t     kind,
	output dcache_pkg::way_idx_t      hit_way,
	output logic                      lru_update_en,
	output dcache_pkg::way_idx_t      lru_way,
	output dcache_pkg::set_idx_t      lru_set
);

	import dcache_pkg::*;
	import lsu_pkg::*;

	way_mask_t way_match;
	logic      is_hit;
	logic      way_can_read;
	logic      way_can_write;

	// A way matches on an equal tag, but only if it grants some access
	always_comb begin
		for (int w = 0; w < way_numb; w++) begin
			way_match[w] = (way_state[w].tag == ldst2.address.tag) &&
				(way_state[w].can_read || way_state[w].can_write);
		end
	end

	// Walk down so that the lowest matching way is the one kept
	always_comb begin
		hit_way = '0;
		for (int w = way_numb - 1; w >= 0; w--) begin
			if (way_match[w])
				hit_way = way_idx_t'(w);
		end
	end

	assign is_hit = |way_match;

	// Privileges of the chosen way decide between hit and miss
	assign way_can_read  = way_state[hit_way].can_read;
	assign way_can_write = way_state[hit_way].can_write;

	// A request has priority over a controller command in the same cycle
	always_comb begin
		kind = idle;
		if (ldst2.valid) begin
			if (ldst2.is_load)
				kind = (is_hit && way_can_read) ? load_hit : load_miss;
			else
				kind = (is_hit && way_can_write) ? store_hit : store_miss;
		end else if (cc_update.data_valid) begin
			// The evict flag turns a plain fill into a replacement
			kind = cc_update.evict ? replacement : data_update;
		end
	end

	// Only hits touch the LRU state of the set
	assign lru_update_en = (kind == load_hit) || (kind == store_hit);
	assign lru_way       = hit_way;
	assign lru_set       = ldst2.address.index;

endmodule

/* data_port_mux.sv */
`timescale 1ns/1ns

module data_port_mux (
	input  lsu_pkg::ldst2_req_t    ldst2,
	input  lsu_pkg::cc_update_t    cc_update,
	input  lsu_pkg::access_kind_t  kind,
	input  dcache_pkg::way_idx_t   hit_way,
	output logic                   rd_en,
	output dcache_pkg::bank_addr_t rd_addr,
	output dcache_pkg::byte_mask_t wr_en,
	output dcache_pkg::bank_addr_t wr_addr,
	output dcache_pkg::line_t      wr_data
);

	import dcache_pkg::*;
	import lsu_pkg::*;

	bank_addr_t hit_line;
	bank_addr_t cmd_line;

	// Requests address the way that hit, commands the way they carry
	assign hit_line = {ldst2.address.index, hit_way};
	assign cmd_line = {ldst2.address.index, cc_update.way};

	// Stores and controller fills both take their bytes from store_value
	assign wr_data = ldst2.store_value;

	always_comb begin
		rd_en   = 1'b0;
		rd_addr = hit_line;
		wr_en   = '0;
		wr_addr = hit_line;
		case (kind)
			load_hit: begin
				rd_en = 1'b1;
			end
			store_hit: begin
				// Only the bytes selected by the store mask change
				wr_en = ldst2.store_mask;
			end
			data_update: begin
				// A fill always replaces the whole line
				wr_en   = '1;
				wr_addr = cmd_line;
			end
			replacement: begin
				// The victim is read and the new line written in one cycle
				// since port one returns the old contents
				rd_en   = 1'b1;
				rd_addr = cmd_line;
				wr_en   = '1;
				wr_addr = cmd_line;
			end
			default: begin
				// Misses and idle cycles leave the bank alone
				rd_en = 1'b0;
			end
		endcase
	end

endmodule

/* data_bank.sv */
`timescale 1ns/1ns

module data_bank (
	input  logic                   clk,
	input  logic                   rd_en,
	input  dcache_pkg::bank_addr_t rd_addr,
	input  dcache_pkg::byte_mask_t wr_en,
	input  dcache_pkg::bank_addr_t wr_addr,
	input  dcache_pkg::line_t      wr_data,
	input  logic                   snoop_en,
	input  dcache_pkg::bank_addr_t snoop_addr,
	output dcache_pkg::line_t      rd_data,
	output dcache_pkg::line_t      snoop_data
);

	import dcache_pkg::*;

	localparam int depth = set_numb * way_numb;

	// One entry per set and way
	line_t mem [depth];

	line_t snoop_line;
	logic  snoop_same_line;

	// The snoop port sees bytes written in the same cycle to its line
	assign snoop_same_line = (wr_addr == snoop_addr);

	always_comb begin
		for (int b = 0; b < line_bytes; b++) begin
			if (snoop_same_line && wr_en[b])
				snoop_line[b*8 +: 8] = wr_data[b*8 +: 8];
			else
				snoop_line[b*8 +: 8] = mem[snoop_addr][b*8 +: 8];
		end
	end

	always_ff @(posedge clk) begin
		// Byte lanes are written independently
		for (int b = 0; b < line_bytes; b++) begin
			if (wr_en[b])
				mem[wr_addr][b*8 +: 8] <= wr_data[b*8 +: 8];
		end
		// Port one samples the array before this cycle's write lands
		if (rd_en)
			rd_data <= mem[rd_addr];
		if (snoop_en)
			snoop_data <= snoop_line;
	end

endmodule

/* result_register.sv */
`timescale 1ns/1ns

module result_register (
	input  logic                              clk,
	input  logic                              reset,
	input  lsu_pkg::ldst2_req_t               ldst2,
	input  lsu_pkg::way_state_array_t         way_state,
	input  lsu_pkg::cc_update_t               cc_update,
	input  lsu_pkg::access_kind_t             kind,
	input  dcache_pkg::line_t                 rd_data,
	output lsu_pkg::ldst3_result_t            result,
	output dcache_pkg::line_t                 cache_line,
	output logic [lsu_pkg::thread_numb-1:0]   thread_sleep
);

	import dcache_pkg::*;
	import lsu_pkg::*;

	logic                   is_miss;
	logic                   valid_q;
	logic                   miss_q;
	logic                   evict_q;
	thread_id_t             thread_q;
	dcache_address_t        address_q;
	dcache_address_t        address_next;
	byte_mask_t             mask_q;
	line_t                  store_value_q;
	logic [thread_numb-1:0] sleep_next;

	assign is_miss = (kind == load_miss) || (kind == store_miss);

	// An eviction reports the victim line, whose tag comes from the command way
	always_comb begin
		address_next = ldst2.address;
		if (kind == replacement) begin
			address_next.tag    = way_state[cc_update.way].tag;
			address_next.offset = '0;
		end
	end

	// The missing thread is put to sleep for a single cycle
	always_comb begin
		sleep_next = '0;
		if (is_miss)
			sleep_next[ldst2.thread_id] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			valid_q      <= 1'b0;
			miss_q       <= 1'b0;
			evict_q      <= 1'b0;
			thread_sleep <= '0;
		end else begin
			// Only load hits bring data back to writeback
			valid_q      <= (kind == load_hit);
			miss_q       <= is_miss;
			evict_q      <= (kind == replacement);
			thread_sleep <= sleep_next;
		end
	end

	// Payload follows the request every cycle
	always_ff @(posedge clk) begin
		thread_q      <= ldst2.thread_id;
		address_q     <= address_next;
		mask_q        <= ldst2.store_mask;
		store_value_q <= ldst2.store_value;
	end

	always_comb begin
		result.valid      = valid_q;
		result.miss       = miss_q;
		result.evict      = evict_q;
		result.thread_id  = thread_q;
		result.address    = address_q;
		result.store_mask = mask_q;
	end

	// On a miss the controller gets back the value the request carried
	assign cache_line = miss_q ? store_value_q : rd_data;

endmodule

/* lsu_stage3.sv */
`timescale 1ns/1ns

module lsu_stage3 (
	input  logic                             clk,
	input  logic                             reset,
	input  lsu_pkg::ldst2_req_t              ldst2,
	input  lsu_pkg::way_state_array_t        way_state,
	input  lsu_pkg::cc_update_t              cc_update,
	input  lsu_pkg::snoop_req_t              snoop,
	output lsu_pkg::ldst3_result_t           result,
	output dcache_pkg::line_t                cache_line,
	output logic [lsu_pkg::thread_numb-1:0]  thread_sleep,
	output logic                             lru_update_en,
	output dcache_pkg::way_idx_t             lru_way,
	output dcache_pkg::set_idx_t             lru_set,
	output dcache_pkg::line_t                snoop_data
);

	import dcache_pkg::*;
	import lsu_pkg::*;

	access_kind_t kind;
	way_idx_t     hit_way;
	logic         rd_en;
	bank_addr_t   rd_addr;
	byte_mask_t   wr_en;
	bank_addr_t   wr_addr;
	line_t        wr_data;
	line_t        rd_data;

	// Tag compare and classification of the cycle
	hit_miss_unit u_hit_miss (
		.ldst2         (ldst2),
		.way_state     (way_state),
		.cc_update     (cc_update),
		.kind          (kind),
		.hit_way       (hit_way),
		.lru_update_en (lru_update_en),
		.lru_way       (lru_way),
		.lru_set       (lru_set)
	);

	// Port one controls for the data bank
	data_port_mux u_port_mux (
		.ldst2     (ldst2),
		.cc_update (cc_update),
		.kind      (kind),
		.hit_way   (hit_way),
		.rd_en     (rd_en),
		.rd_addr   (rd_addr),
		.wr_en     (wr_en),
		.wr_addr   (wr_addr),
		.wr_data   (wr_data)
	);

	// The controller snoop drives port two directly
	data_bank u_data_bank (
		.clk        (clk),
		.rd_en      (rd_en),
		.rd_addr    (rd_addr),
		.wr_en      (wr_en),
		.wr_addr    (wr_addr),
		.wr_data    (wr_data),
		.snoop_en   (snoop.valid),
		.snoop_addr ({snoop.set, snoop.way}),
		.rd_data    (rd_data),
		.snoop_data (snoop_data)
	);

	result_register u_result (
		.clk          (clk),
		.reset        (reset),
		.ldst2        (ldst2),
		.way_state    (way_state),
		.cc_update    (cc_update),
		.kind         (kind),
		.rd_data      (rd_data),
		.result       (result),
		.cache_line   (cache_line),
		.thread_sleep (thread_sleep)
	);

endmodule

/* tb_lsu_stage3.sv */
`timescale 1ns/1ns

module tb_lsu_stage3;

	import dcache_pkg::*;
	import lsu_pkg::*;

	localparam int clk_period = 40;
	// Rough length of all directed tests in cycles
	localparam int expected_cycles = 300;
	// The run limit leaves ample margin over that length
	localparam int max_cycles = expected_cycles * 6 + 200;

	logic                   clk;
	logic                   reset;
	ldst2_req_t             ldst2;
	way_state_array_t       way_state;
	cc_update_t             cc_update;
	snoop_req_t             snoop;
	ldst3_result_t          result;
	line_t                  cache_line;
	logic [thread_numb-1:0] thread_sleep;
	logic                   lru_update_en;
	way_idx_t               lru_way;
	set_idx_t               lru_set;
	line_t                  snoop_data;

	// Expected contents of every set and way
	line_t       model [set_numb][way_numb];
	logic [31:0] lfsr_state;
	int          cycle_count = 0;

	lsu_stage3 dut (.*);

	initial begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	// Ends the run if the tests stall
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= max_cycles) begin
			$display("Timeout: tests still running after %0d cycles", max_cycles);
			$display("Done: errors found");
			$fatal(1, "Cycle limit reached");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("CHECK FAILED at %0t ns: %s", $time, msg);
		$display("Done: errors found");
		$fatal(1, "Stopped at first mismatch");
	endtask

	// Galois LFSR stepped once per bit handed out
	function automatic logic next_random_bit();
		logic out;
		out = lfsr_state[0];
		lfsr_state = lfsr_state >> 1;
		if (out)
			lfsr_state = lfsr_state ^ 32'ha300_0000;
		return out;
	endfunction

	function automatic line_t random_line();
		line_t v;
		for (int i = 0; i < $bits(line_t); i++)
			v[i] = next_random_bit();
		return v;
	endfunction

	function automatic byte_mask_t random_mask();
		byte_mask_t v;
		for (int i = 0; i < line_bytes; i++)
			v[i] = next_random_bit();
		return v;
	endfunction

	function automatic thread_id_t random_thread();
		thread_id_t v;
		for (int i = 0; i < $bits(thread_id_t); i++)
			v[i] = next_random_bit();
		return v;
	endfunction

	// Each way gets a distinct tag whose upper bits hold the set
	function automatic tag_t tag_of(input set_idx_t s, input way_idx_t w);
		return {s, 14'h0c3a, w};
	endfunction

	function automatic dcache_address_t make_address(input tag_t t, input set_idx_t s,
			input offset_t off);
		dcache_address_t a;
		a.tag = t;
		a.index = s;
		a.offset = off;
		return a;
	endfunction

	// Expected line after a masked store
	function automatic line_t merge_bytes(input line_t old_line, input line_t new_line,
			input byte_mask_t mask);
		line_t merged;
		merged = old_line;
		for (int b = 0; b < line_bytes; b++)
			if (mask[b])
				merged[b*8 +: 8] = new_line[b*8 +: 8];
		return merged;
	endfunction

	task automatic set_way_state(input set_idx_t s, input way_mask_t rd, input way_mask_t wr);
		for (int w = 0; w < way_numb; w++) begin
			way_state[w].tag = tag_of(s, way_idx_t'(w));
			way_state[w].can_read = rd[w];
			way_state[w].can_write = wr[w];
		end
	endtask

	task automatic clear_inputs();
		ldst2 = '0;
		cc_update = '0;
		snoop = '0;
	endtask

	// Holds a request for one cycle and checks the LRU outputs while it is present
	task automatic issue_request(input thread_id_t tid, input logic is_load,
			input dcache_address_t addr, input line_t value, input byte_mask_t mask,
			input logic lru_hit, input way_idx_t way);
		ldst2.valid = 1'b1;
		ldst2.thread_id = tid;
		ldst2.is_load = is_load;
		ldst2.address = addr;
		ldst2.store_value = value;
		ldst2.store_mask = mask;
		#(clk_period / 4);
		if (lru_hit) begin
			assert (lru_update_en === 1'b1 && lru_way === way && lru_set === addr.index)
				else report_mismatch("LRU update wrong for a hit");
		end else begin
			assert (lru_update_en === 1'b0) else report_mismatch("LRU update raised on a miss");
		end
		@(negedge clk);
		clear_inputs();
	endtask

	// A controller command rides on the request's address and store value
	task automatic issue_command(input set_idx_t s, input offset_t off, input way_idx_t w,
			input logic evict, input line_t value);
		// The command carries the tag of the incoming line, not the one of the victim
		ldst2.address = make_address(~tag_of(s, w), s, off);
		ldst2.store_value = value;
		cc_update.data_valid = 1'b1;
		cc_update.evict = evict;
		cc_update.way = w;
		#(clk_period / 4);
		assert (lru_update_en === 1'b0) else report_mismatch("LRU update raised by a command");
		@(negedge clk);
		clear_inputs();
	endtask

	// Loads one line through a read-enabled way and compares it with the model
	task automatic load_and_check(input set_idx_t s, input way_idx_t w);
		thread_id_t tid;
		tid = random_thread();
		set_way_state(s, 4'b1111, 4'b1111);
		issue_request(tid, 1'b1, make_address(tag_of(s, w), s, 6'h04), '0, '0, 1'b1, w);
		assert (result.valid === 1'b1 && result.miss === 1'b0 && result.thread_id === tid)
			else report_mismatch("load hit flags wrong");
		assert (cache_line === model[s][w]) else report_mismatch("load returned wrong line");
	endtask

	task automatic fill_then_load();
		line_t fill;
		set_idx_t s;
		for (int i = 0; i < 4; i++) begin
			s = set_idx_t'(3 + i * 7);
			set_way_state(s, 4'b1111, 4'b1111);
			for (int w = 0; w < way_numb; w++) begin
				fill = random_line();
				issue_command(s, '0, way_idx_t'(w), 1'b0, fill);
				model[s][w] = fill;
				assert (result.valid === 1'b0 && result.miss === 1'b0 && result.evict === 1'b0)
					else report_mismatch("data update raised a result flag");
			end
			for (int w = 0; w < way_numb; w++)
				load_and_check(s, way_idx_t'(w));
		end
	endtask

	task automatic store_then_load();
		line_t value;
		byte_mask_t mask;
		way_idx_t w;
		for (int i = 0; i < 8; i++) begin
			w = way_idx_t'(i);
			value = random_line();
			mask = random_mask();
			set_way_state(5'd10, 4'b1111, 4'b1111);
			issue_request(random_thread(), 1'b0, make_address(tag_of(5'd10, w), 5'd10, '0),
				value, mask, 1'b1, w);
			model[10][w] = merge_bytes(model[10][w], value, mask);
			assert (result.valid === 1'b0 && result.miss === 1'b0)
				else report_mismatch("store hit raised valid or miss");
			load_and_check(5'd10, w);
		end
	endtask

	task automatic misses();
		line_t value;
		byte_mask_t mask;
		thread_id_t tid;
		dcache_address_t addr;
		for (int w = 0; w < way_numb; w++) begin
			// Load whose tag matches no way, then a store to a read-only way
			for (int k = 0; k < 2; k++) begin
				tid = random_thread();
				value = random_line();
				mask = random_mask();
				addr = make_address(tag_of(5'd17, way_idx_t'(w)) ^ (k == 0 ? 21'h100000 : 21'h0),
					5'd17, 6'h2a);
				set_way_state(5'd17, 4'b1111, 4'b1111 & ~(4'b0001 << w));
				issue_request(tid, k == 0, addr, value, mask, 1'b0, '0);
				assert (result.miss === 1'b1 && result.valid === 1'b0 && result.address === addr)
					else report_mismatch("miss flags or address wrong");
				assert (result.thread_id === tid && result.store_mask === mask)
					else report_mismatch("miss thread or store mask wrong");
				assert (thread_sleep === (8'b1 << tid) && cache_line === value)
					else report_mismatch("thread sleep or returned store value wrong");
				@(negedge clk);
				assert (thread_sleep === '0) else report_mismatch("thread sleep held past one cycle");
			end
			load_and_check(5'd17, way_idx_t'(w));
		end
	endtask

	task automatic replace_and_check();
		line_t fresh;
		for (int w = 0; w < way_numb; w++) begin
			fresh = random_line();
			set_way_state(5'd24, 4'b1111, 4'b1111);
			issue_command(5'd24, 6'h13, way_idx_t'(w), 1'b1, fresh);
			assert (result.evict === 1'b1 && result.valid === 1'b0 && result.miss === 1'b0)
				else report_mismatch("replacement flags wrong");
			assert (cache_line === model[24][w]) else report_mismatch("victim line wrong");
			assert (result.address === make_address(tag_of(5'd24, way_idx_t'(w)), 5'd24, '0))
				else report_mismatch("eviction address wrong");
			model[24][w] = fresh;
			load_and_check(5'd24, way_idx_t'(w));
		end
	endtask

	task automatic snoop_lines();
		line_t value;
		byte_mask_t mask;
		for (int i = 0; i < 16; i++) begin
			snoop.valid = 1'b1;
			snoop.set = set_idx_t'(3 + (i / 4) * 7);
			snoop.way = way_idx_t'(i);
			@(negedge clk);
			clear_inputs();
			assert (snoop_data === model[3 + (i / 4) * 7][i % 4])
				else report_mismatch("snoop returned wrong line");
		end
		// Snoop racing a store hit to the same line sees the new bytes
		value = random_line();
		mask = random_mask();
		set_way_state(5'd3, 4'b1111, 4'b1111);
		snoop.valid = 1'b1;
		snoop.set = 5'd3;
		snoop.way = 2'd2;
		issue_request(random_thread(), 1'b0, make_address(tag_of(5'd3, 2'd2), 5'd3, '0),
			value, mask, 1'b1, 2'd2);
		model[3][2] = merge_bytes(model[3][2], value, mask);
		assert (snoop_data === model[3][2]) else report_mismatch("snoop missed same-cycle store");
		load_and_check(5'd3, 2'd2);
	endtask

	initial begin
		lfsr_state = 32'h184a_4c19;
		reset = 1'b1;
		clear_inputs();
		way_state = '0;
		repeat (3) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		assert (result.valid === 1'b0 && result.miss === 1'b0 && result.evict === 1'b0 &&
			thread_sleep === '0) else report_mismatch("outputs not cleared by reset");
		fill_then_load();
		store_then_load();
		misses();
		replace_and_check();
		snoop_lines();
		$display("Done: no errors");
		$finish;
	end

endmodule

/* files.f */
dcache_pkg.sv
lsu_pkg.sv
hit_miss_unit.sv
data_port_mux.sv
data_bank.sv
result_register.sv
lsu_stage3.sv
tb_lsu_stage3.sv

/* Bender.yml */
package:
  name: lsu_stage3

sources:
  - dcache_pkg.sv
  - lsu_pkg.sv
  - hit_miss_unit.sv
  - data_port_mux.sv
  - data_bank.sv
  - result_register.sv
  - lsu_stage3.sv
  - target: test
    files:
      - tb_lsu_stage3.sv
